// File: source/decodePkg.sv
`default_nettype none

package decodePkg;

	typedef logic [4:0] regAddr_t;

	// raw instruction word split into its R-type fields
	typedef struct packed {
		logic [6:0] funct7;
		regAddr_t   rs2;
		regAddr_t   rs1;
		logic [2:0] funct3;
		regAddr_t   rd;
		logic [6:0] opcode;
	} instrFields_t;

	typedef enum logic [6:0] {
		opLui    = 7'b0110111,
		opAuipc  = 7'b0010111,
		opSystem = 7'b1110011,   // ecall
		opImm    = 7'b0010011,
		opOp     = 7'b0110011,
		opImm32  = 7'b0011011,
		opOp32   = 7'b0111011,
		opJal    = 7'b1101111,
		opJalr   = 7'b1100111,
		opBranch = 7'b1100011,
		opLoad   = 7'b0000011,
		opStore  = 7'b0100011
	} opcode_t;

	localparam logic [6:0] funct7Base   = 7'b0000000;
	localparam logic [6:0] funct7Alt    = 7'b0100000;   // sub, sra
	localparam logic [6:0] funct7MulDiv = 7'b0000001;

	// codes 10 and 11 unused
	typedef enum logic [5:0] {
		aluNone   = 6'd0,
		aluAddi   = 6'd1,
		aluSlti   = 6'd2,
		aluSltiu  = 6'd3,
		aluXori   = 6'd4,
		aluOri    = 6'd5,
		aluAndi   = 6'd6,
		aluSlli   = 6'd7,
		aluSrli   = 6'd8,
		aluSrai   = 6'd9,
		aluAdd    = 6'd12,
		aluSub    = 6'd13,
		aluSll    = 6'd14,
		aluSlt    = 6'd15,
		aluSltu   = 6'd16,
		aluXor    = 6'd17,
		aluSrl    = 6'd18,
		aluSra    = 6'd19,
		aluOr     = 6'd20,
		aluAnd    = 6'd21,
		aluAddiw  = 6'd22,
		aluSlliw  = 6'd23,
		aluSrliw  = 6'd24,
		aluSraiw  = 6'd25,
		aluAddw   = 6'd26,
		aluSubw   = 6'd27,
		aluSllw   = 6'd28,
		aluSrlw   = 6'd29,
		aluSraw   = 6'd30,
		aluMul    = 6'd31,
		aluMulh   = 6'd32,
		aluMulhsu = 6'd33,
		aluMulhu  = 6'd34,
		aluDiv    = 6'd35,
		aluDivu   = 6'd36,
		aluRem    = 6'd37,
		aluRemu   = 6'd38,
		aluMulw   = 6'd39,
		aluDivw   = 6'd40,
		aluDivuw  = 6'd41,
		aluRemw   = 6'd42,
		aluRemuw  = 6'd43
	} aluOp_t;

	typedef enum logic [2:0] {
		loadLd  = 3'd0,
		loadLb  = 3'd1,
		loadLh  = 3'd2,
		loadLw  = 3'd3,
		loadLbu = 3'd4,
		loadLhu = 3'd5,
		loadLwu = 3'd6
	} loadType_t;

	typedef enum logic [1:0] {
		storeSd = 2'd0,
		storeSw = 2'd1,
		storeSh = 2'd2,
		storeSb = 2'd3
	} storeType_t;

	typedef enum logic [2:0] {
		brNone = 3'd0,
		brBeq  = 3'd2,
		brBne  = 3'd3,
		brBlt  = 3'd4,
		brBge  = 3'd5,
		brBltu = 3'd6,
		brBgeu = 3'd7
	} branchType_t;

	typedef enum logic [1:0] {
		opAZero = 2'd0,
		opAReg  = 2'd1,
		opAPc   = 2'd2
	} opASel_t;

	typedef enum logic {
		opBZero = 1'b0,
		opBReg  = 1'b1
	} opBSel_t;

	typedef struct packed {
		logic        regWrite;
		logic        memRead;
		logic        memWrite;
		logic        memOrReg;   // 1 selects load data on writeback
		logic        branch;
		logic        jump;
		logic        jalr;
		logic        ecall;
		aluOp_t      aluOp;
		loadType_t   loadType;
		storeType_t  storeType;
		branchType_t branchType;
	} ctrl_t;

endpackage

`default_nettype wire

// File: source/instrDecoder.sv
`timescale 1ns/10ps
`default_nettype none

module instrDecoder import decodePkg::*; #(
	parameter int dataWidth = 64
) (
	input  instrFields_t         instr,
	output ctrl_t                decCtrl,
	output logic [dataWidth-1:0] decImm,
	output regAddr_t             decRd,
	output regAddr_t             decRs1,
	output regAddr_t             decRs2,
	output opASel_t              opASel,
	output opBSel_t              opBSel
);
	logic [31:0] word;
	logic [dataWidth-1:0] immI;
	logic [dataWidth-1:0] immS;
	logic [dataWidth-1:0] immB;
	logic [dataWidth-1:0] immU;
	logic [dataWidth-1:0] immJ;

	assign word = instr;

	assign immI = {{(dataWidth-12){word[31]}}, word[31:20]};
	assign immS = {{(dataWidth-12){word[31]}}, word[31:25], word[11:7]};
	assign immB = {{(dataWidth-13){word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
	assign immU = {{(dataWidth-32){word[31]}}, word[31:12], 12'b0};
	assign immJ = {{(dataWidth-21){word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};

	function automatic aluOp_t opImmAlu(input logic [6:0] f7, input logic [2:0] f3);
		aluOp_t op;
		op = aluNone;
		case (f3)
			3'b000: op = aluAddi;
			3'b010: op = aluSlti;
			3'b011: op = aluSltiu;
			3'b100: op = aluXori;
			3'b110: op = aluOri;
			3'b111: op = aluAndi;
			// f7[0] is shamt bit 5 on rv64
			3'b001: op = (f7[6:1] == funct7Base[6:1]) ? aluSlli : aluNone;
			default: begin
				if (f7[6:1] == funct7Base[6:1])
					op = aluSrli;
				else if (f7[6:1] == funct7Alt[6:1])
					op = aluSrai;
			end
		endcase
		return op;
	endfunction

	function automatic aluOp_t opImm32Alu(input logic [6:0] f7, input logic [2:0] f3);
		aluOp_t op;
		op = aluNone;
		case ({f7, f3})
			{funct7Base, 3'b001}: op = aluSlliw;
			{funct7Base, 3'b101}: op = aluSrliw;
			{funct7Alt, 3'b101}:  op = aluSraiw;
			default: op = (f3 == 3'b000) ? aluAddiw : aluNone;   // addiw ignores f7
		endcase
		return op;
	endfunction

	function automatic aluOp_t opAlu(input logic [6:0] f7, input logic [2:0] f3);
		aluOp_t op;
		op = aluNone;
		case ({f7, f3})
			{funct7Base, 3'b000}:   op = aluAdd;
			{funct7Alt, 3'b000}:    op = aluSub;
			{funct7Base, 3'b001}:   op = aluSll;
			{funct7Base, 3'b010}:   op = aluSlt;
			{funct7Base, 3'b011}:   op = aluSltu;   // snez too
			{funct7Base, 3'b100}:   op = aluXor;
			{funct7Base, 3'b101}:   op = aluSrl;
			{funct7Alt, 3'b101}:    op = aluSra;
			{funct7Base, 3'b110}:   op = aluOr;
			{funct7Base, 3'b111}:   op = aluAnd;
			{funct7MulDiv, 3'b000}: op = aluMul;
			{funct7MulDiv, 3'b001}: op = aluMulh;
			{funct7MulDiv, 3'b010}: op = aluMulhsu;
			{funct7MulDiv, 3'b011}: op = aluMulhu;
			{funct7MulDiv, 3'b100}: op = aluDiv;
			{funct7MulDiv, 3'b101}: op = aluDivu;
			{funct7MulDiv, 3'b110}: op = aluRem;
			{funct7MulDiv, 3'b111}: op = aluRemu;
			default: op = aluNone;
		endcase
		return op;
	endfunction

	function automatic aluOp_t op32Alu(input logic [6:0] f7, input logic [2:0] f3);
		aluOp_t op;
		op = aluNone;
		case ({f7, f3})
			{funct7Base, 3'b000}:   op = aluAddw;
			{funct7Alt, 3'b000}:    op = aluSubw;
			{funct7Base, 3'b001}:   op = aluSllw;
			{funct7Base, 3'b101}:   op = aluSrlw;
			{funct7Alt, 3'b101}:    op = aluSraw;
			{funct7MulDiv, 3'b000}: op = aluMulw;
			{funct7MulDiv, 3'b100}: op = aluDivw;
			{funct7MulDiv, 3'b101}: op = aluDivuw;
			{funct7MulDiv, 3'b110}: op = aluRemw;
			{funct7MulDiv, 3'b111}: op = aluRemuw;
			default: op = aluNone;
		endcase
		return op;
	endfunction

	always_comb begin
		decCtrl = '0;
		decImm = '0;
		decRd = '0;
		decRs1 = '0;
		decRs2 = '0;
		opASel = opAZero;
		opBSel = opBZero;
		case (instr.opcode)
			opLui: begin
				decCtrl.regWrite = 1'b1;
				decRd = instr.rd;
				decImm = immU;
			end
			opAuipc: begin
				decCtrl.regWrite = 1'b1;
				decCtrl.aluOp = aluAddi;   // pc + imm
				decRd = instr.rd;
				decImm = immU;
				opASel = opAPc;
			end
			opSystem: decCtrl.ecall = 1'b1;
			opImm, opImm32: begin
				decCtrl.regWrite = 1'b1;
				decCtrl.aluOp = (instr.opcode == opImm) ? opImmAlu(instr.funct7, instr.funct3)
					: opImm32Alu(instr.funct7, instr.funct3);
				decRd = instr.rd;
				decRs1 = instr.rs1;
				decImm = immI;
				opASel = opAReg;
			end
			opOp, opOp32: begin
				decCtrl.regWrite = 1'b1;
				decCtrl.aluOp = (instr.opcode == opOp) ? opAlu(instr.funct7, instr.funct3)
					: op32Alu(instr.funct7, instr.funct3);
				decRd = instr.rd;
				decRs1 = instr.rs1;
				decRs2 = instr.rs2;
				opASel = opAReg;
				opBSel = opBReg;
			end
			opJal: begin
				decCtrl.regWrite = 1'b1;
				decCtrl.jump = 1'b1;
				decRd = instr.rd;
				decImm = immJ;
			end
			opJalr: begin
				decCtrl.regWrite = 1'b1;
				decCtrl.jump = 1'b1;
				decCtrl.jalr = 1'b1;
				decRd = instr.rd;
				decRs1 = instr.rs1;
				decImm = immI;
				opASel = opAReg;
			end
			opBranch: begin
				decCtrl.branch = 1'b1;
				case (instr.funct3)
					3'b000: decCtrl.branchType = brBeq;
					3'b001: decCtrl.branchType = brBne;
					3'b100: decCtrl.branchType = brBlt;
					3'b101: decCtrl.branchType = brBge;
					3'b110: decCtrl.branchType = brBltu;
					3'b111: decCtrl.branchType = brBgeu;
					default: decCtrl.branchType = brNone;
				endcase
				decRs1 = instr.rs1;
				decRs2 = instr.rs2;
				decImm = immB;
				opASel = opAReg;
				opBSel = opBReg;
			end
			opLoad: begin
				decCtrl.regWrite = 1'b1;
				decCtrl.memRead = 1'b1;
				decCtrl.memOrReg = 1'b1;
				decCtrl.aluOp = (instr.funct3 == 3'b111) ? aluNone : aluAddi;   // address add
				case (instr.funct3)
					3'b000: decCtrl.loadType = loadLb;
					3'b001: decCtrl.loadType = loadLh;
					3'b010: decCtrl.loadType = loadLw;
					3'b100: decCtrl.loadType = loadLbu;
					3'b101: decCtrl.loadType = loadLhu;
					3'b110: decCtrl.loadType = loadLwu;
					default: decCtrl.loadType = loadLd;
				endcase
				decRd = instr.rd;
				decRs1 = instr.rs1;
				decImm = immI;
				opASel = opAReg;
			end
			opStore: begin
				decCtrl.memWrite = 1'b1;
				decCtrl.aluOp = instr.funct3[2] ? aluNone : aluAddi;
				case (instr.funct3)
					3'b000: decCtrl.storeType = storeSb;
					3'b001: decCtrl.storeType = storeSh;
					3'b010: decCtrl.storeType = storeSw;
					default: decCtrl.storeType = storeSd;
				endcase
				decRs1 = instr.rs1;
				decRs2 = instr.rs2;
				decImm = immS;
				opASel = opAReg;
				opBSel = opBReg;   // store data
			end
			default: ;   // unknown opcode keeps all zero
		endcase
	end

endmodule

`default_nettype wire

// File: source/regRead.sv
`timescale 1ns/10ps
`default_nettype none

module regRead import decodePkg::*; #(
	parameter int dataWidth = 64,
	parameter logic [dataWidth-1:0] stackInit = '0
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 hold,
	input  logic                 wbWrite,
	input  regAddr_t             wbReg,
	input  logic [dataWidth-1:0] wbData,
	input  regAddr_t             decRs1,
	input  regAddr_t             decRs2,
	output logic [dataWidth-1:0] rdData1,
	output logic [dataWidth-1:0] rdData2
);
	logic [dataWidth-1:0] regs [32];

	// x0 is never written, so it stays at its reset zero
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= (i == 2) ? stackInit : '0;   // x2 is sp
			end
		end else if (!hold && wbWrite && wbReg != '0) begin
			regs[wbReg] <= wbData;
		end
	end

	function automatic logic [dataWidth-1:0] readPort(
		input regAddr_t addr,
		input logic bypassEn,
		input regAddr_t bypassReg,
		input logic [dataWidth-1:0] bypassData,
		input logic [dataWidth-1:0] stored
	);
		logic [dataWidth-1:0] value;
		if (addr == '0)
			value = '0;
		else if (bypassEn && bypassReg == addr)
			value = bypassData;   // writeback in flight
		else
			value = stored;
		return value;
	endfunction

	always_comb begin
		rdData1 = readPort(decRs1, wbWrite, wbReg, wbData, regs[decRs1]);
	end

	always_comb begin
		rdData2 = readPort(decRs2, wbWrite, wbReg, wbData, regs[decRs2]);
	end

endmodule

`default_nettype wire

// File: source/idExRegister.sv
`timescale 1ns/10ps
`default_nettype none

module idExRegister import decodePkg::*; #(
	parameter int dataWidth = 64
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 hold,
	input  logic                 flush,
	input  logic                 hazardStall,
	input  logic [dataWidth-1:0] pc,
	input  ctrl_t                decCtrl,
	input  logic [dataWidth-1:0] decImm,
	input  regAddr_t             decRd,
	input  regAddr_t             decRs1,
	input  regAddr_t             decRs2,
	input  opASel_t              opASel,
	input  opBSel_t              opBSel,
	input  logic [dataWidth-1:0] rdData1,
	input  logic [dataWidth-1:0] rdData2,
	output ctrl_t                ctrl,
	output logic [dataWidth-1:0] readData1,
	output logic [dataWidth-1:0] readData2,
	output logic [dataWidth-1:0] imm,
	output logic [dataWidth-1:0] pcOut,
	output logic [dataWidth-1:0] epc,
	output regAddr_t             destReg,
	output regAddr_t             rs,
	output regAddr_t             rt
);
	typedef struct packed {
		ctrl_t                ctrl;
		logic [dataWidth-1:0] op1;
		logic [dataWidth-1:0] op2;
		logic [dataWidth-1:0] imm;
		logic [dataWidth-1:0] pc;
		logic [dataWidth-1:0] epc;
		regAddr_t             rd;
		regAddr_t             rs;
		regAddr_t             rt;
	} stage_t;

	stage_t stageNext;
	stage_t stageQ;

	always_comb begin
		stageNext.ctrl = decCtrl;
		case (opASel)
			opAReg: stageNext.op1 = rdData1;
			opAPc: stageNext.op1 = pc;   // auipc
			default: stageNext.op1 = '0;
		endcase
		stageNext.op2 = (opBSel == opBReg) ? rdData2 : '0;
		stageNext.imm = decImm;
		stageNext.pc = pc;
		stageNext.epc = decCtrl.ecall ? pc + dataWidth'(4) : '0;   // return past the ecall
		stageNext.rd = decRd;
		stageNext.rs = decRs1;
		stageNext.rt = decRs2;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			stageQ <= '0;
		end else if (!hold) begin
			if (flush || hazardStall)
				stageQ <= '0;   // bubble
			else
				stageQ <= stageNext;
		end
	end

	assign ctrl = stageQ.ctrl;
	assign readData1 = stageQ.op1;
	assign readData2 = stageQ.op2;
	assign imm = stageQ.imm;
	assign pcOut = stageQ.pc;
	assign epc = stageQ.epc;
	assign destReg = stageQ.rd;
	assign rs = stageQ.rs;
	assign rt = stageQ.rt;

endmodule

`default_nettype wire

// File: source/decodeStage.sv
`timescale 1ns/10ps
`default_nettype none

module decodeStage import decodePkg::*; #(
	parameter int dataWidth = 64,
	parameter logic [dataWidth-1:0] stackInit = 'h7fff_fff0
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic [dataWidth-1:0] pc,
	input  instrFields_t         instr,
	input  logic                 wbWrite,
	input  regAddr_t             wbReg,
	input  logic [dataWidth-1:0] wbData,
	input  logic                 flush,
	input  logic                 hazardStall,
	input  logic                 dcacheStall,
	input  logic                 icacheStall,
	output ctrl_t                ctrl,
	output logic [dataWidth-1:0] readData1,
	output logic [dataWidth-1:0] readData2,
	output logic [dataWidth-1:0] imm,
	output logic [dataWidth-1:0] pcOut,
	output logic [dataWidth-1:0] epc,
	output regAddr_t             destReg,
	output regAddr_t             rs,
	output regAddr_t             rt
);
	logic hold;
	ctrl_t decCtrl;
	logic [dataWidth-1:0] decImm;
	regAddr_t decRd;
	regAddr_t decRs1;
	regAddr_t decRs2;
	opASel_t opASel;
	opBSel_t opBSel;
	logic [dataWidth-1:0] rdData1;
	logic [dataWidth-1:0] rdData2;

	assign hold = dcacheStall | icacheStall;   // freezes regfile and ID/EX

	instrDecoder #(
		.dataWidth(dataWidth)
	) u_decoder (
		.instr  (instr),
		.decCtrl(decCtrl),
		.decImm (decImm),
		.decRd  (decRd),
		.decRs1 (decRs1),
		.decRs2 (decRs2),
		.opASel (opASel),
		.opBSel (opBSel)
	);

	regRead #(
		.dataWidth(dataWidth),
		.stackInit(stackInit)
	) u_regRead (
		.clk    (clk),
		.reset  (reset),
		.hold   (hold),
		.wbWrite(wbWrite),
		.wbReg  (wbReg),
		.wbData (wbData),
		.decRs1 (decRs1),
		.decRs2 (decRs2),
		.rdData1(rdData1),
		.rdData2(rdData2)
	);

	idExRegister #(
		.dataWidth(dataWidth)
	) u_idEx (
		.clk        (clk),
		.reset      (reset),
		.hold       (hold),
		.flush      (flush),
		.hazardStall(hazardStall),
		.pc         (pc),
		.decCtrl    (decCtrl),
		.decImm     (decImm),
		.decRd      (decRd),
		.decRs1     (decRs1),
		.decRs2     (decRs2),
		.opASel     (opASel),
		.opBSel     (opBSel),
		.rdData1    (rdData1),
		.rdData2    (rdData2),
		.ctrl       (ctrl),
		.readData1  (readData1),
		.readData2  (readData2),
		.imm        (imm),
		.pcOut      (pcOut),
		.epc        (epc),
		.destReg    (destReg),
		.rs         (rs),
		.rt         (rt)
	);

endmodule

`default_nettype wire

// File: test/decodeStage_assert.sv
`timescale 1ns/10ps
`default_nettype none

module decodeStage_assert import decodePkg::*; #(
	parameter int dataWidth = 64
) (
	input logic                 clk,
	input logic                 reset,
	input logic                 hold,
	input logic                 flush,
	input logic                 hazardStall,
	input ctrl_t                ctrl,
	input logic [dataWidth-1:0] readData1,
	input logic [dataWidth-1:0] readData2,
	input logic [dataWidth-1:0] imm,
	input logic [dataWidth-1:0] pcOut,
	input logic [dataWidth-1:0] epc,
	input regAddr_t             destReg,
	input regAddr_t             rs,
	input regAddr_t             rt
);
	localparam int outWidth = $bits(ctrl_t) + 5 * dataWidth + 3 * $bits(regAddr_t);

	logic [outWidth-1:0] outs;   // every ID/EX output in one vector

	assign outs = {ctrl, readData1, readData2, imm, pcOut, epc, destReg, rs, rt};

	holdKeepsOutputs: assert property (@(posedge clk) disable iff (reset) hold |=> $stable(outs))
		else $error("ID/EX outputs changed while hold was high");

	bubbleClears: assert property (@(posedge clk) disable iff (reset)
		!hold && (flush || hazardStall) |=> outs == '0)
		else $error("ID/EX outputs not zero after a bubble");

	resetClears: assert property (@(posedge clk) reset |=> outs == '0)
		else $error("ID/EX outputs not zero after reset");

endmodule

bind idExRegister decodeStage_assert #(
	.dataWidth(dataWidth)
) u_assert (
	.clk(clk), .reset(reset), .hold(hold), .flush(flush), .hazardStall(hazardStall),
	.ctrl(ctrl), .readData1(readData1), .readData2(readData2), .imm(imm),
	.pcOut(pcOut), .epc(epc), .destReg(destReg), .rs(rs), .rt(rt)
);

`default_nettype wire

// File: test/decodeStage_tb.sv
`timescale 1ns/10ps
`default_nettype none

module decodeStage_tb import decodePkg::*; #(
	parameter int seed = 46
);
	localparam int dataWidth = 64;
	localparam logic [dataWidth-1:0] stackInit = 64'h0000_003f_ffff_ff00;
	localparam int phaseLen = 60;
	localparam int bubbleLen = 30;
	localparam int stallLen = 80;
	localparam int plannedCycles = 5 + 3 + 3 * phaseLen + bubbleLen + stallLen + 3;

	typedef logic [dataWidth-1:0] word_t;

	typedef struct packed {
		ctrl_t    ctrl;
		word_t    readData1;
		word_t    readData2;
		word_t    imm;
		word_t    pcOut;
		word_t    epc;
		regAddr_t destReg;
		regAddr_t rs;
		regAddr_t rt;
	} result_t;

	// grouped so each test phase draws from a contiguous index range
	localparam logic [6:0] opTable [12] = '{opImm, opImm32, opOp, opOp32, opBranch, opStore,
		opLoad, opLui, opAuipc, opJal, opJalr, opSystem};

	logic clk;
	logic reset;
	word_t pc;
	instrFields_t instr;
	logic wbWrite;
	regAddr_t wbReg;
	word_t wbData;
	logic flush;
	logic hazardStall;
	logic dcacheStall;
	logic icacheStall;
	ctrl_t ctrl;
	word_t readData1;
	word_t readData2;
	word_t imm;
	word_t pcOut;
	word_t epc;
	regAddr_t destReg;
	regAddr_t rs;
	regAddr_t rt;

	word_t shadow [32];
	result_t expected;
	int errorCount;
	int seedState;

	decodeStage #(
		.dataWidth(dataWidth),
		.stackInit(stackInit)
	) u_dut (
		.clk(clk), .reset(reset), .pc(pc), .instr(instr),
		.wbWrite(wbWrite), .wbReg(wbReg), .wbData(wbData),
		.flush(flush), .hazardStall(hazardStall),
		.dcacheStall(dcacheStall), .icacheStall(icacheStall),
		.ctrl(ctrl), .readData1(readData1), .readData2(readData2), .imm(imm),
		.pcOut(pcOut), .epc(epc), .destReg(destReg), .rs(rs), .rt(rt)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic aluOp_t aluRef(input logic [6:0] opc, input logic [6:0] f7,
		input logic [2:0] f3);
		logic [5:0] code;
		logic base;
		logic alt;
		logic mext;
		code = 6'd0;
		base = (f7 == 7'h00);
		alt = (f7 == 7'h20);
		mext = (f7 == 7'h01);
		case (opc)
			opImm: begin
				if (f3 == 3'd1)
					code = (f7[6:1] == 6'h00) ? 6'd7 : 6'd0;   // shamt[5] lives in f7[0]
				else if (f3 == 3'd5)
					code = (f7[6:1] == 6'h00) ? 6'd8 : (f7[6:1] == 6'h10) ? 6'd9 : 6'd0;
				else
					code = (f3 == 3'd0) ? 6'd1 : (f3 < 3'd6) ? 6'(f3) : 6'(f3) - 6'd1;
			end
			opImm32: begin
				if (f3 == 3'd0)
					code = 6'd22;
				else if (base && f3 == 3'd1)
					code = 6'd23;
				else if (f3 == 3'd5)
					code = base ? 6'd24 : alt ? 6'd25 : 6'd0;
			end
			opOp: begin
				if (mext)
					code = 6'd31 + 6'(f3);
				else if (base)
					code = (f3 == 3'd0) ? 6'd12 : (f3 < 3'd6) ? 6'd13 + 6'(f3) : 6'd14 + 6'(f3);
				else if (alt)
					code = (f3 == 3'd0) ? 6'd13 : (f3 == 3'd5) ? 6'd19 : 6'd0;
			end
			opOp32: begin
				if (base)
					code = (f3 == 3'd0) ? 6'd26 : (f3 == 3'd1) ? 6'd28 : (f3 == 3'd5) ? 6'd29 : 6'd0;
				else if (alt)
					code = (f3 == 3'd0) ? 6'd27 : (f3 == 3'd5) ? 6'd30 : 6'd0;
				else if (mext)
					code = (f3 == 3'd0) ? 6'd39 : (f3 >= 3'd4) ? 6'd36 + 6'(f3) : 6'd0;
			end
			opAuipc: code = 6'd1;
			opLoad: code = (f3 == 3'd7) ? 6'd0 : 6'd1;
			opStore: code = f3[2] ? 6'd0 : 6'd1;
			default: code = 6'd0;
		endcase
		return aluOp_t'(code);
	endfunction

	// register value as seen in the decode cycle, same-cycle write-back included
	function automatic word_t readReg(input regAddr_t addr);
		if (addr == '0)
			return '0;
		if (wbWrite && wbReg == addr)
			return wbData;
		return shadow[addr];
	endfunction

	function automatic result_t decodeRef(input instrFields_t in, input word_t pcIn);
		result_t r;
		logic [31:0] w;
		word_t immI;
		word_t immS;
		word_t immB;
		word_t immU;
		word_t immJ;
		logic useRd;
		logic useRs1;
		logic useRs2;
		logic usePc;
		r = '0;
		w = in;
		immI = 64'($signed(w[31:20]));
		immS = 64'($signed({w[31:25], w[11:7]}));
		immB = 64'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
		immU = 64'($signed({w[31:12], 12'h000}));
		immJ = 64'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
		{useRd, useRs1, useRs2, usePc} = 4'b0000;
		r.ctrl.aluOp = aluRef(in.opcode, in.funct7, in.funct3);
		case (in.opcode)
			opLui: {r.ctrl.regWrite, useRd, r.imm} = {2'b11, immU};
			opAuipc: {r.ctrl.regWrite, useRd, usePc, r.imm} = {3'b111, immU};
			opSystem: r.ctrl.ecall = 1'b1;
			opImm, opImm32: {r.ctrl.regWrite, useRd, useRs1, r.imm} = {3'b111, immI};
			opOp, opOp32: {r.ctrl.regWrite, useRd, useRs1, useRs2} = 4'b1111;
			opJal: {r.ctrl.regWrite, r.ctrl.jump, useRd, r.imm} = {3'b111, immJ};
			opJalr: {r.ctrl.regWrite, r.ctrl.jump, r.ctrl.jalr, useRd, useRs1, r.imm} = {5'h1f, immI};
			opBranch: begin
				{r.ctrl.branch, useRs1, useRs2, r.imm} = {3'b111, immB};
				case (in.funct3)
					3'd0: r.ctrl.branchType = brBeq;
					3'd1: r.ctrl.branchType = brBne;
					3'd4: r.ctrl.branchType = brBlt;
					3'd5: r.ctrl.branchType = brBge;
					3'd6: r.ctrl.branchType = brBltu;
					3'd7: r.ctrl.branchType = brBgeu;
					default: r.ctrl.branchType = brNone;
				endcase
			end
			opLoad: begin
				{r.ctrl.regWrite, r.ctrl.memRead, r.ctrl.memOrReg, useRd, useRs1} = 5'h1f;
				r.imm = immI;
				case (in.funct3)
					3'd0: r.ctrl.loadType = loadLb;
					3'd1: r.ctrl.loadType = loadLh;
					3'd2: r.ctrl.loadType = loadLw;
					3'd4: r.ctrl.loadType = loadLbu;
					3'd5: r.ctrl.loadType = loadLhu;
					3'd6: r.ctrl.loadType = loadLwu;
					default: r.ctrl.loadType = loadLd;
				endcase
			end
			opStore: begin
				{r.ctrl.memWrite, useRs1, useRs2, r.imm} = {3'b111, immS};
				r.ctrl.storeType = in.funct3[2] ? storeSd : storeType_t'(2'd3 - in.funct3[1:0]);
			end
			default: r.ctrl = '0;
		endcase
		r.destReg = useRd ? in.rd : '0;
		r.rs = useRs1 ? in.rs1 : '0;
		r.rt = useRs2 ? in.rs2 : '0;
		r.readData1 = usePc ? pcIn : useRs1 ? readReg(in.rs1) : '0;
		r.readData2 = useRs2 ? readReg(in.rs2) : '0;
		r.pcOut = pcIn;
		r.epc = r.ctrl.ecall ? pcIn + 64'd4 : '0;
		return r;
	endfunction

	task automatic stopRun();
		errorCount++;
		$display("Finished with errors");
		$fatal(1, "decode stage output mismatch");
	endtask

	task automatic checkCtrl(input string name, input ctrl_t got, input ctrl_t exp);
		if (got !== exp) begin
			$display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
			stopRun();
		end
	endtask

	task automatic checkData(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
			stopRun();
		end
	endtask

	task automatic checkReg(input string name, input regAddr_t got, input regAddr_t exp);
		if (got !== exp) begin
			$display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
			stopRun();
		end
	endtask

	// expectation formed at the edge, outputs compared half a cycle later
	initial begin
		expected = '0;
		forever begin
			@(posedge clk);
			if (reset) begin
				for (int i = 0; i < 32; i++)
					shadow[i] = (i == 2) ? stackInit : '0;
				expected = '0;
			end else if (!(dcacheStall || icacheStall)) begin
				expected = (flush || hazardStall) ? '0 : decodeRef(instr, pc);
				if (wbWrite && wbReg != '0)
					shadow[wbReg] = wbData;
			end
			@(negedge clk);
			checkCtrl("ctrl", ctrl, expected.ctrl);
			checkData("readData1", readData1, expected.readData1);
			checkData("readData2", readData2, expected.readData2);
			checkData("imm", imm, expected.imm);
			checkData("pcOut", pcOut, expected.pcOut);
			checkData("epc", epc, expected.epc);
			checkReg("destReg", destReg, expected.destReg);
			checkReg("rs", rs, expected.rs);
			checkReg("rt", rt, expected.rt);
		end
	end

	initial begin
		#(plannedCycles * 4 + 100);
		$display("watchdog expired before the test sequence completed");
		$display("Finished with errors");
		$fatal(1, "timeout");
	end

	function automatic instrFields_t randInstr(input logic [6:0] opc);
		instrFields_t i;
		i = $urandom;
		i.opcode = opc;
		case ($urandom_range(3))   // mostly legal funct7 values
			0: i.funct7 = 7'h00;
			1: i.funct7 = 7'h20;
			2: i.funct7 = 7'h01;
			default: ;
		endcase
		if (opc == opLoad)
			i.funct3 = 3'($urandom_range(6));
		else if (opc == opStore)
			i.funct3 = 3'($urandom_range(3));
		else if (opc == opSystem)
			i = 32'h0000_0073;
		return i;
	endfunction

	task automatic nextCycle();
		@(posedge clk);
		#1;
	endtask

	task automatic driveRandom(input int lo, input int hi);
		instr = randInstr(opTable[$urandom_range(hi, lo)]);
		pc = {32'h0, $urandom} & ~word_t'(3);
		wbWrite = ($urandom_range(99) < 60);
		wbReg = regAddr_t'($urandom_range(31));
		wbData = {$urandom, $urandom};
		if ($urandom_range(3) == 0)
			wbReg = instr.rs1;   // same-cycle bypass
		else if ($urandom_range(7) == 0)
			wbReg = '0;
	endtask

	initial begin
		seedState = $urandom(seed);
		errorCount = 0;
		reset = 1'b1;
		pc = '0;
		instr = '0;
		{wbWrite, wbReg, wbData} = '0;
		{flush, hazardStall, dcacheStall, icacheStall} = 4'b0000;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;
		instr = instrFields_t'({12'h123, 5'd2, 3'd0, 5'd5, opImm});   // addi x5, x2, 0x123
		pc = 64'h1000;
		nextCycle();
		instr = instrFields_t'({12'hfff, 5'd0, 3'd0, 5'd6, opImm});   // addi x6, x0, -1
		nextCycle();
		instr = instrFields_t'(32'h0000_0073);   // ecall
		pc = 64'h1008;
		nextCycle();
		repeat (phaseLen) begin
			driveRandom(2, 5);
			nextCycle();
		end
		repeat (phaseLen) begin
			driveRandom(0, 3);
			nextCycle();
		end
		repeat (phaseLen) begin
			driveRandom(4, 10);
			nextCycle();
		end
		repeat (bubbleLen) begin
			driveRandom(0, 11);
			flush = ($urandom_range(4) == 0);
			hazardStall = ($urandom_range(4) == 0);
			nextCycle();
		end
		{flush, hazardStall} = 2'b00;
		repeat (stallLen) begin
			driveRandom(0, 11);
			dcacheStall = ($urandom_range(2) == 0);
			icacheStall = ($urandom_range(3) == 0);
			nextCycle();
		end
		{dcacheStall, icacheStall, wbWrite} = 3'b000;
		repeat (3) nextCycle();
		if (errorCount == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
source/decodePkg.sv
source/instrDecoder.sv
source/regRead.sv
source/idExRegister.sv
source/decodeStage.sv
test/decodeStage_assert.sv
test/decodeStage_tb.sv

// File: Makefile
# Verilator build and run of the decode stage testbench
VERILATOR ?= verilator
TOP       ?= decodeStage_tb
SEED      ?= 46
LOG       ?= sim.log
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASSTEXT  := Finished with no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(OBJDIR) and $(LOG)"
	@echo "variables: VERILATOR TOP SEED LOG OBJDIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Gseed=$(SEED) -f vlog.f --Mdir $(OBJDIR)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASSTEXT)" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
